//--- source/idct_consts.svh
/* widths and matrix constants for the HEVC column inverse transform
   sizes are fixed by the 8-point matrix, so nothing here is meant to be overridden */

`ifndef IDCT_CONSTS_SVH
`define IDCT_CONSTS_SVH

// datapath widths
`define IDCT_SAMPLE_W 16            // input coefficient
`define IDCT_COEF_W   8             // signed matrix entry, |89| fits
`define IDCT_ACC_W    27            // eight 24-bit products without overflow
`define IDCT_OUT_W    8             // emitted slice of the rounded sum

`define IDCT_LANES    8             // one lane per output row

// output rounding, (sum + 2^11) >>> 12
`define IDCT_ROUND    2048
`define IDCT_SHIFT    12

// the seven distinct magnitudes of the HEVC 8-point matrix
`define IDCT_M0       64
`define IDCT_M1       89
`define IDCT_M2       83
`define IDCT_M3       75
`define IDCT_M4       50
`define IDCT_M5       36
`define IDCT_M6       18

`endif

//--- source/idct_pkg.sv
/* shared types of the column transform
   widths come from idct_consts.svh */

`default_nettype none

`include "idct_consts.svh"

package idct_pkg;

    typedef logic signed [`IDCT_SAMPLE_W-1:0] sample_t;   // input coefficient
    typedef logic signed [`IDCT_COEF_W-1:0]   coef_t;     // matrix entry
    typedef logic signed [`IDCT_ACC_W-1:0]    acc_t;      // lane sum
    typedef logic        [`IDCT_OUT_W-1:0]    out_t;      // output sample

    typedef logic [2:0] beat_t;     // beat or row index

    // same encoding as the old mode flag
    typedef enum logic {
        mode_4pt = 1'b0,
        mode_8pt = 1'b1
    } mode_t;

endpackage

`default_nettype wire

//--- source/idct_sequencer.sv
/* beat counter of the column stage
   a column starts after reset or after the last beat of the previous one,
   in_mode is only looked at on beat 0 */

`default_nettype none

module idct_sequencer (
    input  wire logic              clk,
    input  wire logic              rst_b,
    input  wire logic              in_valid,
    input  idct_pkg::mode_t        in_mode,
    output idct_pkg::beat_t        beat_index,
    output idct_pkg::mode_t        beat_mode,
    output logic                   acc_en,
    output logic                   acc_clear,
    output logic                   col_done,
    output idct_pkg::mode_t        col_mode
);

    idct_pkg::beat_t beat_cnt;
    idct_pkg::mode_t mode_q;        // mode of the column in progress
    logic            first_beat;
    logic            last_beat;

    assign first_beat = (beat_cnt == 3'd0);

    // mode is live on beat 0, held afterwards
    assign beat_mode  = first_beat ? in_mode : mode_q;
    assign beat_index = beat_cnt;
    assign last_beat  = (beat_mode == idct_pkg::mode_8pt) ? (beat_cnt == 3'd7)
                                                          : (beat_cnt == 3'd3);

    assign acc_en    = in_valid;
    assign acc_clear = first_beat;  // lanes load instead of add

    always_ff @(posedge clk)
    begin
        if (!rst_b)
        begin
            beat_cnt <= '0;
            mode_q   <= idct_pkg::mode_4pt;
            col_done <= 1'b0;
            col_mode <= idct_pkg::mode_4pt;
        end
        else
        begin
            col_done <= in_valid && last_beat;
            if (in_valid)
            begin
                beat_cnt <= last_beat ? 3'd0 : beat_cnt + 3'd1;
                if (first_beat)
                    mode_q <= in_mode;
                if (last_beat)
                    col_mode <= beat_mode;  // travels with the done pulse
            end
        end
    end

    // a column is at least four beats long
    a_done_single: assert property (@(posedge clk) disable iff (!rst_b)
        col_done |=> !col_done)
        else $error("col_done high on two consecutive cycles");

endmodule

`default_nettype wire

//--- source/idct_coef_rom.sv
/* combinational HEVC matrix lookup, entry (beat, lane) for every lane
   4-point mode uses the even rows of the 8-point matrix, lanes 4..7 read zero */

`default_nettype none

`include "idct_consts.svh"

module idct_coef_rom (
    input  idct_pkg::beat_t        beat_index,
    input  idct_pkg::mode_t        beat_mode,
    output idct_pkg::coef_t        lane_coef [`IDCT_LANES]
);

    idct_pkg::beat_t                 row;       // row of the 8-point matrix
    logic [`IDCT_LANES-1:0][2:0]     mag_sel;   // magnitude index per lane
    logic [`IDCT_LANES-1:0]          neg;       // lane takes the negative

    function automatic idct_pkg::coef_t mag_of(input logic [2:0] sel);
        case (sel)
            3'd0:    return idct_pkg::coef_t'(`IDCT_M0);
            3'd1:    return idct_pkg::coef_t'(`IDCT_M1);
            3'd2:    return idct_pkg::coef_t'(`IDCT_M2);
            3'd3:    return idct_pkg::coef_t'(`IDCT_M3);
            3'd4:    return idct_pkg::coef_t'(`IDCT_M4);
            3'd5:    return idct_pkg::coef_t'(`IDCT_M5);
            3'd6:    return idct_pkg::coef_t'(`IDCT_M6);
            default: return '0;
        endcase
    endfunction

    assign row = (beat_mode == idct_pkg::mode_8pt) ? beat_index : {beat_index[1:0], 1'b0};

    // lane 7 on the left
    always_comb
    begin
        case (row)
            3'd0:    begin mag_sel = {8{3'd0}};                                  neg = 8'b0000_0000; end
            3'd1:    begin mag_sel = {3'd1, 3'd3, 3'd4, 3'd6, 3'd6, 3'd4, 3'd3, 3'd1}; neg = 8'b1111_0000; end
            3'd2:    begin mag_sel = {3'd2, 3'd5, 3'd5, 3'd2, 3'd2, 3'd5, 3'd5, 3'd2}; neg = 8'b0011_1100; end
            3'd3:    begin mag_sel = {3'd3, 3'd6, 3'd1, 3'd4, 3'd4, 3'd1, 3'd6, 3'd3}; neg = 8'b1000_1110; end
            3'd4:    begin mag_sel = {8{3'd0}};                                  neg = 8'b0110_0110; end
            3'd5:    begin mag_sel = {3'd4, 3'd1, 3'd6, 3'd3, 3'd3, 3'd6, 3'd1, 3'd4}; neg = 8'b1011_0010; end
            3'd6:    begin mag_sel = {3'd5, 3'd2, 3'd2, 3'd5, 3'd5, 3'd2, 3'd2, 3'd5}; neg = 8'b0101_1010; end
            default: begin mag_sel = {3'd6, 3'd4, 3'd3, 3'd1, 3'd1, 3'd3, 3'd4, 3'd6}; neg = 8'b1010_1010; end
        endcase

        for (int i = 0; i < `IDCT_LANES; i++)
        begin
            if (beat_mode == idct_pkg::mode_4pt && i >= 4)
                lane_coef[i] = '0;
            else if (neg[i])
                lane_coef[i] = -mag_of(mag_sel[i]);
            else
                lane_coef[i] = mag_of(mag_sel[i]);
        end
    end

    // the sequencer wraps after beat 3 in 4-point mode
    always_comb
    begin
        if (beat_mode == idct_pkg::mode_4pt)
            a_4pt_beat: assert (beat_index < 3'd4)
                else $error("beat index %0d in 4-point mode", beat_index);
    end

endmodule

`default_nettype wire

//--- source/idct_mac_lane.sv
/* one output row, sum of sample times matrix entry over the column
   the first beat loads the product, later beats add, no saturation */

`default_nettype none

`include "idct_consts.svh"

module idct_mac_lane (
    input  wire logic              clk,
    input  wire logic              rst_b,
    input  wire logic              acc_en,
    input  wire logic              acc_clear,
    input  idct_pkg::sample_t      sample,
    input  idct_pkg::coef_t        coef,
    output idct_pkg::acc_t         lane_acc
);

    logic signed [`IDCT_SAMPLE_W+`IDCT_COEF_W-1:0] product;   // full 24-bit product

    assign product = sample * coef;

    always_ff @(posedge clk)
    begin
        if (!rst_b)
            lane_acc <= '0;
        else if (acc_en)
        begin
            if (acc_clear)
                lane_acc <= idct_pkg::acc_t'(product);  // new column
            else
                lane_acc <= lane_acc + idct_pkg::acc_t'(product);
        end
        // gaps hold the partial sum
    end

endmodule

`default_nettype wire

//--- source/idct_drain.sv
/* output stage, one row per cycle after col_done
   row 0 leaves on the capture edge, the rest follow from the captured copy,
   only bits [19:12] of the rounded sum are kept so large sums wrap */

`default_nettype none

`include "idct_consts.svh"

module idct_drain (
    input  wire logic              clk,
    input  wire logic              rst_b,
    input  wire logic              col_done,
    input  idct_pkg::mode_t        col_mode,
    input  idct_pkg::acc_t         lane_acc [`IDCT_LANES],
    output logic                   out_valid,
    output idct_pkg::mode_t        out_mode,
    output idct_pkg::out_t         out_sample
);

    idct_pkg::acc_t  row_buf [`IDCT_LANES];     // finished column
    idct_pkg::beat_t cur_row;                   // row now on the output
    idct_pkg::beat_t next_row;
    idct_pkg::beat_t last_row;
    logic            pending;

    function automatic idct_pkg::out_t round_row(input idct_pkg::acc_t sum);
        idct_pkg::acc_t r;
        r = sum + idct_pkg::acc_t'(`IDCT_ROUND);
        return r[`IDCT_SHIFT +: `IDCT_OUT_W];
    endfunction

    assign last_row = (out_mode == idct_pkg::mode_8pt) ? 3'd7 : 3'd3;
    assign next_row = cur_row + 3'd1;
    assign pending  = out_valid && (cur_row != last_row);

    // lanes may already clear for the next column after this edge
    always_ff @(posedge clk)
    begin
        if (col_done)
            row_buf <= lane_acc;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_b)
        begin
            out_valid  <= 1'b0;
            out_mode   <= idct_pkg::mode_4pt;
            out_sample <= '0;
            cur_row    <= '0;
        end
        else if (col_done)
        begin
            out_valid  <= 1'b1;
            out_mode   <= col_mode;
            out_sample <= round_row(lane_acc[0]);   // straight from the lanes
            cur_row    <= '0;
        end
        else if (pending)
        begin
            cur_row    <= next_row;
            out_sample <= round_row(row_buf[next_row]);
        end
        else
            out_valid <= 1'b0;  // sample holds its last value
    end

    // needs at least as many input beats as output rows
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_b)
        col_done |-> !pending)
        else $error("new column finished before the previous one drained");

endmodule

`default_nettype wire

//--- source/idct_col_top.sv
/* streaming HEVC inverse transform column stage, 4 or 8 points
   first output row two edges after the last accepted beat, no back-pressure,
   the consumer must take every cycle with out_valid high */

`default_nettype none

`include "idct_consts.svh"

module idct_col_top (
    input  wire logic              clk,
    input  wire logic              rst_b,
    input  wire logic              in_valid,
    input  idct_pkg::mode_t        in_mode,
    input  idct_pkg::sample_t      in_sample,
    output logic                   out_valid,
    output idct_pkg::mode_t        out_mode,
    output idct_pkg::out_t         out_sample
);

    idct_pkg::beat_t beat_index;
    idct_pkg::mode_t beat_mode;
    logic            acc_en;
    logic            acc_clear;
    logic            col_done;
    idct_pkg::mode_t col_mode;

    idct_pkg::coef_t lane_coef [`IDCT_LANES];
    idct_pkg::acc_t  lane_acc  [`IDCT_LANES];

    idct_sequencer i_seq (
        .clk        (clk),
        .rst_b      (rst_b),
        .in_valid   (in_valid),
        .in_mode    (in_mode),
        .beat_index (beat_index),
        .beat_mode  (beat_mode),
        .acc_en     (acc_en),
        .acc_clear  (acc_clear),
        .col_done   (col_done),
        .col_mode   (col_mode)
    );

    idct_coef_rom i_rom (
        .beat_index (beat_index),
        .beat_mode  (beat_mode),
        .lane_coef  (lane_coef)
    );

    // one accumulator per output row
    for (genvar i = 0; i < `IDCT_LANES; i++)
    begin : g_lane
        idct_mac_lane i_lane (
            .clk       (clk),
            .rst_b     (rst_b),
            .acc_en    (acc_en),
            .acc_clear (acc_clear),
            .sample    (in_sample),
            .coef      (lane_coef[i]),
            .lane_acc  (lane_acc[i])
        );
    end

    idct_drain i_drain (
        .clk        (clk),
        .rst_b      (rst_b),
        .col_done   (col_done),
        .col_mode   (col_mode),
        .lane_acc   (lane_acc),
        .out_valid  (out_valid),
        .out_mode   (out_mode),
        .out_sample (out_sample)
    );

endmodule

`default_nettype wire

//--- tests/idct_ref_model.svh
/* reference HEVC 8-point inverse transform matrix and expected output rows
   include inside a module, after idct_consts.svh */

`ifndef IDCT_REF_MODEL_SVH
`define IDCT_REF_MODEL_SVH

// entry (k, n), basis row k, output row n
localparam int HEVC8 [8][8] = '{
    '{64,  64,  64,  64,  64,  64,  64,  64},
    '{89,  75,  50,  18, -18, -50, -75, -89},
    '{83,  36, -36, -83, -83, -36,  36,  83},
    '{75, -18, -89, -50,  50,  89,  18, -75},
    '{64, -64, -64,  64,  64, -64, -64,  64},
    '{50, -89,  18,  75, -75, -18,  89, -50},
    '{36, -83,  83, -36, -36,  83, -83,  36},
    '{18, -50,  75, -89,  89, -75,  50, -18}
};

// rounded output row n, only the low 8 bits survive
function automatic logic [7:0] ref_row(input bit is8, input int s [8], input int n);
    longint sum;
    sum = 0;
    for (int k = 0; k < 8; k++)
    begin
        if (is8)
            sum += longint'(s[k] * HEVC8[k][n]);
        else if (k < 4)
            sum += longint'(s[k] * HEVC8[2 * k][n]);   // 4-point basis k is 8-point row 2k
    end
    sum = (sum + `IDCT_ROUND) >>> `IDCT_SHIFT;
    return sum[7:0];
endfunction

`endif

//--- tests/idct_col_tb.sv
/* table columns go in back to back wherever the drain allows
   each row is checked for value, mode and the cycle it appears on */

`default_nettype none

`include "idct_consts.svh"

module idct_col_tb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "idct_ref_model.svh"

    localparam int NT = 16;

    logic              clk = 1'b0;
    logic              rst_b;
    logic              in_valid;
    idct_pkg::mode_t   in_mode;
    idct_pkg::sample_t in_sample;
    logic              out_valid;
    idct_pkg::mode_t   out_mode;
    idct_pkg::out_t    out_sample;

    int cyc = 0;
    int err_cnt = 0;
    int err_base = 0;       // errors before the current test
    int done_cnt = 0;

    // expected rows in output order
    logic [7:0] exp_val  [$];
    bit         exp_mode [$];
    int         exp_cyc  [$];
    bit         exp_last [$];
    int         exp_test [$];

    // mode (1 = 8-point) and gap flag ahead of samples 0..7
    int tbl [NT][10] = '{
        '{1, 0,   4096,      0,      0,      0,      0,     0,    0,      0},  // dc
        '{1, 0,      0,   4096,      0,      0,      0,     0,    0,      0},
        '{1, 0,      0,      0,  -4096,      0,      0,     0,    0,      0},
        '{1, 0,      0,      0,      0,   4096,      0,     0,    0,      0},
        '{1, 0,      0,      0,      0,      0,  20000,     0,    0,      0},  // wraps
        '{1, 0,      0,      0,      0,      0,      0,  2000,    0,      0},
        '{1, 0,      0,      0,      0,      0,      0,     0, 4096,      0},
        '{1, 0,      0,      0,      0,      0,      0,     0,    0,  -3000},
        '{0, 0,   4096,   1000,  -2500,    700,      0,     0,    0,      0},
        '{0, 0,   -300,  32767, -32768,     12,      0,     0,    0,      0},
        '{1, 0,    100,   -200,    300,   -400,    500,  -600,  700,   -800},
        '{1, 0,  32767, -32768,  32767, -32768,  32767, -32768, 32767, -32768},
        '{0, 0,   5000,  -5000,   2500,   1234,      0,     0,    0,      0},
        '{1, 1,    100,   -200,    300,   -400,    500,  -600,  700,   -800},
        '{0, 1,   4096,   1000,  -2500,    700,      0,     0,    0,      0},
        '{1, 1,  32767, -32768,  32767, -32768,  32767, -32768, 32767, -32768}
    };

    idct_col_top i_dut (
        .clk        (clk),
        .rst_b      (rst_b),
        .in_valid   (in_valid),
        .in_mode    (in_mode),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_mode   (out_mode),
        .out_sample (out_sample)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
        begin
            $display("FAILED t=%0t %s got 'h%0h expected 'h%0h", $time, name, got, want);
            err_cnt++;
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk)
    begin
        int tid;
        if (rst_b && out_valid)
        begin
            if (exp_val.size() == 0)
            begin
                $display("ERROR at %0t: out_valid high while no row is expected", $time);
                err_cnt++;
            end
            else
            begin
                tid = exp_test.pop_front();
                check("out_sample", 32'(out_sample), 32'(exp_val.pop_front()));
                check("out_mode", 32'(out_mode), 32'(exp_mode.pop_front()));
                check("row_cycle", cyc, exp_cyc.pop_front());
                if (exp_last.pop_front())
                begin
                    $display("test %0d: %0d errors", tid, err_cnt - err_base);
                    err_base = err_cnt;
                    done_cnt++;
                end
            end
        end
    end

    initial
    begin
        int smp [8];
        int n;
        int n_prev;
        int last_cyc;
        int wait_cnt;
        bit is8;

        void'($urandom(41968));
        rst_b     = 1'b0;
        in_valid  = 1'b0;
        in_mode   = idct_pkg::mode_4pt;
        in_sample = '0;
        n_prev    = 0;
        last_cyc  = -100;
        repeat (2) @(negedge clk);
        rst_b = 1'b1;

        repeat (20)
        begin
            @(negedge clk);
            check("out_valid", 32'(out_valid), 32'd0);
            check("out_sample", 32'(out_sample), 32'd0);
            check("out_mode", 32'(out_mode), 32'd0);
        end
        $display("test reset: %0d errors", err_cnt);
        err_base = err_cnt;

        for (int t = 0; t < NT; t++)
        begin
            is8 = (tbl[t][0] != 0);
            n   = is8 ? 8 : 4;
            for (int k = 0; k < 8; k++)
                smp[k] = tbl[t][k + 2];
            // short column after a long one must not end before the drain is free
            while (cyc + n - 1 < last_cyc + n_prev)
                @(negedge clk);
            for (int k = 0; k < n; k++)
            begin
                if (k > 0 && tbl[t][1] != 0)
                    repeat ($urandom % 3) @(negedge clk);
                in_valid  = 1'b1;
                in_mode   = idct_pkg::mode_t'((k == 0) ? is8 : !is8);  // later beats flip it
                in_sample = idct_pkg::sample_t'(smp[k]);
                if (k == n - 1)
                begin
                    last_cyc = cyc;
                    for (int r = 0; r < n; r++)
                    begin
                        exp_val.push_back(ref_row(is8, smp, r));
                        exp_mode.push_back(is8);
                        exp_cyc.push_back(cyc + 2 + r);     // two edges to row 0, one row per cycle after
                        exp_last.push_back(r == n - 1);
                        exp_test.push_back(t);
                    end
                end
                @(negedge clk);
                in_valid = 1'b0;
            end
            n_prev = n;
        end

        wait_cnt = 0;
        while (exp_val.size() != 0 && wait_cnt < 100)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_val.size() != 0)
        begin
            $display("timeout: %0d expected rows never came out", exp_val.size());
            err_cnt++;
        end
        repeat (10) @(negedge clk);     // stray rows show up in the monitor

        $display("done: %0d of %0d columns, %0d errors", done_cnt, NT, err_cnt);
        if (err_cnt == 0 && done_cnt == NT)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
+incdir+tests
source/idct_pkg.sv
source/idct_sequencer.sv
source/idct_coef_rom.sv
source/idct_mac_lane.sv
source/idct_drain.sv
source/idct_col_top.sv
tests/idct_col_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the column transform testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module idct_col_tb -f list.f -o idct_sim \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/idct_sim)"
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
